// ==== tb.f ====
common/ooo_pkg.sv
common/dispatch_if.sv
issue/issue_stage.sv
issue/register_file.sv
logic/reorder_buffer.sv
logic/reservation_station.sv
logic/ooo_core.sv
test/ooo_core_asserts.sv
test/ooo_core_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module ooo_core_tb \
  -f tb.f -o ooo_core_sim &&
./obj_dir/ooo_core_sim ||
exit 1

// ==== test/ooo_core_tb.sv ====
`timescale 1ns/1ps

module ooo_core_tb;
  import ooo_pkg::*;

  localparam int MAX_INST   = 64;
  localparam int MODE_GAP   = 0;  // random idle cycles first
  localparam int MODE_BURST = 1;  // right after the previous one
  localparam int MODE_DRAIN = 2;  // only after every older commit

  logic      clk_100mhz;
  logic      sys_rst;
  logic      i_inst_valid;
  inst_t     i_inst;
  logic      o_inst_ready;
  logic      o_commit_valid;
  reg_addr_t o_commit_rd;
  xlen_t     o_commit_value;

  // stimulus table, expected columns filled by the register model
  string     tbl_name   [MAX_INST];
  int        tbl_mode   [MAX_INST];
  inst_t     tbl_inst   [MAX_INST];
  logic      tbl_commit [MAX_INST];
  reg_addr_t tbl_rd     [MAX_INST];
  xlen_t     tbl_val    [MAX_INST];
  int        tbl_before [MAX_INST];  // commits due ahead of this entry

  xlen_t  model_regs [32];
  int     n_inst;
  int     n_expected;
  int     n_commits;
  int     chk_ix;
  int     chain_lo;  // table range of the dependent chain
  int     chain_hi;
  logic   saw_stall;
  integer seed;

  // station as deep as the rob, so the rob is what fills up
  ooo_core #(.RS_DEPTH(ROB_DEPTH)) ooo_core_inst (
    .clk_100mhz(clk_100mhz), .sys_rst(sys_rst),
    .i_inst_valid(i_inst_valid), .i_inst(i_inst), .o_inst_ready(o_inst_ready),
    .o_commit_valid(o_commit_valid), .o_commit_rd(o_commit_rd),
    .o_commit_value(o_commit_value)
  );

  always #5 clk_100mhz = ~clk_100mhz;

  function automatic inst_t r_type(input logic [2:0] f3, input logic [6:0] f7,
                                   input reg_addr_t rd, input reg_addr_t rs1,
                                   input reg_addr_t rs2);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic inst_t i_type(input logic [2:0] f3, input reg_addr_t rd,
                                   input reg_addr_t rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, OPC_OPIMM};
  endfunction

  task automatic report_fail(input string what);
    $display("%s", what);
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (actual !== expected) begin
      report_fail($sformatf("Fail %s: expected 0x%08h, actual 0x%08h", name, expected, actual));
    end
  endtask

  // appends one entry and steps the ISA model in program order
  task automatic add(input string name, input int mode, input inst_t word);
    xlen_t a;
    xlen_t b;
    xlen_t r;
    logic  is_imm;
    is_imm = (word[6:0] == OPC_OPIMM);
    a = model_regs[word[19:15]];
    b = is_imm ? {{20{word[31]}}, word[31:20]} : model_regs[word[24:20]];
    case (word[14:12])
      3'd0:    r = (!is_imm && word[30]) ? a - b : a + b;
      3'd1:    r = a << b[4:0];
      3'd2:    r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3:    r = (a < b) ? 32'd1 : 32'd0;
      3'd4:    r = a ^ b;
      3'd5:    r = word[30] ? xlen_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    r = a | b;
      default: r = a & b;
    endcase
    tbl_name[n_inst]   = name;
    tbl_mode[n_inst]   = mode;
    tbl_inst[n_inst]   = word;
    tbl_commit[n_inst] = is_imm || (word[6:0] == OPC_OP);
    tbl_rd[n_inst]     = word[11:7];
    tbl_val[n_inst]    = r;
    tbl_before[n_inst] = n_expected;
    if (tbl_commit[n_inst]) begin
      n_expected++;
      if (word[11:7] != 5'd0) begin
        model_regs[word[11:7]] = r;  // x0 stays zero
      end
    end
    n_inst++;
  endtask

  task automatic build_table();
    for (int r = 0; r < 32; r++) begin
      model_regs[r] = '0;
    end
    n_inst     = 0;
    n_expected = 0;
    add("addi const", MODE_GAP, i_type(3'd0, 5'd1, 5'd0, 12'd5));
    add("addi const", MODE_GAP, i_type(3'd0, 5'd2, 5'd0, 12'hffd));
    add("addi const", MODE_GAP, i_type(3'd0, 5'd3, 5'd0, 12'h7ff));
    add("addi const", MODE_GAP, i_type(3'd0, 5'd4, 5'd0, 12'h800));
    add("addi const", MODE_GAP, i_type(3'd0, 5'd5, 5'd0, 12'd1));
    add("r add", MODE_BURST, r_type(3'd0, 7'h00, 5'd6, 5'd1, 5'd2));
    add("r sub", MODE_BURST, r_type(3'd0, 7'h20, 5'd7, 5'd6, 5'd4));
    add("r sll", MODE_BURST, r_type(3'd1, 7'h00, 5'd8, 5'd7, 5'd5));
    add("r slt", MODE_BURST, r_type(3'd2, 7'h00, 5'd9, 5'd2, 5'd1));
    add("r sltu", MODE_BURST, r_type(3'd3, 7'h00, 5'd10, 5'd2, 5'd1));
    add("r xor", MODE_BURST, r_type(3'd4, 7'h00, 5'd11, 5'd8, 5'd2));
    add("r srl", MODE_BURST, r_type(3'd5, 7'h00, 5'd12, 5'd4, 5'd5));
    add("r sra", MODE_BURST, r_type(3'd5, 7'h20, 5'd13, 5'd4, 5'd5));
    add("r or", MODE_BURST, r_type(3'd6, 7'h00, 5'd14, 5'd13, 5'd9));
    add("r and", MODE_BURST, r_type(3'd7, 7'h00, 5'd15, 5'd14, 5'd3));
    add("r sra neg", MODE_BURST, r_type(3'd5, 7'h20, 5'd16, 5'd2, 5'd5));
    add("r slt neg", MODE_BURST, r_type(3'd2, 7'h00, 5'd17, 5'd10, 5'd16));
    add("i slli", MODE_GAP, i_type(3'd1, 5'd18, 5'd16, 12'd4));
    add("i slti", MODE_GAP, i_type(3'd2, 5'd19, 5'd18, 12'hfff));
    add("i sltiu", MODE_GAP, i_type(3'd3, 5'd20, 5'd2, 12'd1));
    add("i xori", MODE_GAP, i_type(3'd4, 5'd21, 5'd20, 12'hfff));
    add("i srli", MODE_GAP, i_type(3'd5, 5'd22, 5'd21, 12'd28));
    add("i srai", MODE_GAP, i_type(3'd5, 5'd23, 5'd4, 12'h403));  // shamt 3
    add("i ori", MODE_GAP, i_type(3'd6, 5'd24, 5'd22, 12'h030));
    add("i andi", MODE_GAP, i_type(3'd7, 5'd25, 5'd24, 12'h00c));
    // dependent chain with no idle cycles, enough to stall issue
    chain_lo = n_inst;
    for (int k = 0; k < 10; k++) begin
      add("chain addi", MODE_BURST, i_type(3'd0, 5'd26, 5'd27, 12'(k + 1)));
      add("chain xor", MODE_BURST, r_type(3'd4, 7'h00, 5'd27, 5'd26, 5'd3));
    end
    chain_hi = n_inst;
    add("x0 write", MODE_GAP, i_type(3'd0, 5'd0, 5'd1, 12'd9));
    add("x0 read", MODE_GAP, r_type(3'd0, 7'h00, 5'd28, 5'd0, 5'd1));
    add("skip load", MODE_BURST, {12'd4, 5'd1, 3'd2, 5'd29, 7'b0000011});
    add("skip branch", MODE_BURST, {7'd0, 5'd2, 5'd1, 3'd0, 5'd8, 7'b1100011});
    add("skip system", MODE_GAP, 32'h0000_0073);
    add("after skip", MODE_BURST, i_type(3'd0, 5'd29, 5'd0, 12'd77));
    add("after skip", MODE_BURST, r_type(3'd0, 7'h00, 5'd30, 5'd29, 5'd0));
    add("rename old", MODE_BURST, i_type(3'd0, 5'd31, 5'd0, 12'd100));
    add("rename young", MODE_BURST, i_type(3'd0, 5'd31, 5'd0, 12'd200));
    add("rename read", MODE_BURST, r_type(3'd0, 7'h00, 5'd6, 5'd31, 5'd0));
    add("final read", MODE_DRAIN, i_type(3'd0, 5'd8, 5'd31, 12'd0));
    add("final read", MODE_GAP, r_type(3'd0, 7'h00, 5'd9, 5'd26, 5'd27));
    add("final read", MODE_GAP, r_type(3'd0, 7'h00, 5'd12, 5'd31, 5'd1));
  endtask

  task automatic wait_commits(input int target);
    int cycles;
    cycles = 0;
    while (n_commits < target) begin
      @(posedge clk_100mhz);
      cycles++;
      if (cycles > 400) begin
        report_fail($sformatf("timeout: %0d of %0d commits seen", n_commits, target));
      end
    end
  endtask

  // ready is sampled mid-cycle, the transfer is the next rising edge
  task automatic wait_accept(input int ix);
    int   cycles;
    logic taken;
    cycles = 0;
    taken  = 1'b0;
    while (!taken) begin
      @(negedge clk_100mhz);
      taken = o_inst_ready;
      if (!taken && ix >= chain_lo && ix < chain_hi) begin
        saw_stall = 1'b1;
      end
      @(posedge clk_100mhz);
      cycles++;
      if (!taken && cycles > 100) begin
        report_fail($sformatf("timeout: entry %0d (%s) never accepted", ix, tbl_name[ix]));
      end
    end
  endtask

  task automatic feed_table();
    int gap;
    for (int i = 0; i < n_inst; i++) begin
      gap = (tbl_mode[i] == MODE_GAP) ? $unsigned($random(seed)) % 4 : 0;
      if (tbl_mode[i] == MODE_DRAIN) begin
        i_inst_valid <= 1'b0;
        wait_commits(tbl_before[i]);
      end
      if (gap > 0) begin
        i_inst_valid <= 1'b0;
        repeat (gap) @(posedge clk_100mhz);
      end
      i_inst_valid <= 1'b1;
      i_inst       <= tbl_inst[i];
      wait_accept(i);
    end
    i_inst_valid <= 1'b0;
  endtask

  // commit monitor, walks the table past entries that retire nothing
  always @(negedge clk_100mhz) begin
    if (!sys_rst && o_commit_valid) begin
      while (chk_ix < n_inst && !tbl_commit[chk_ix]) begin
        chk_ix++;
      end
      if (chk_ix >= n_inst) begin
        report_fail("a commit appeared with no instruction left to retire");
      end else begin
        check($sformatf("%s #%0d rd", tbl_name[chk_ix], chk_ix),
              32'(tbl_rd[chk_ix]), 32'(o_commit_rd));
        check($sformatf("%s #%0d value", tbl_name[chk_ix], chk_ix),
              tbl_val[chk_ix], o_commit_value);
        chk_ix++;
        n_commits++;
      end
    end
  end

  initial begin
    clk_100mhz   = 1'b0;
    sys_rst      = 1'b1;
    i_inst_valid = 1'b0;
    i_inst       = '0;
    n_commits    = 0;
    chk_ix       = 0;
    saw_stall    = 1'b0;
    seed         = 32'h2409_ad76;
    build_table();
    repeat (8) @(posedge clk_100mhz);
    sys_rst <= 1'b0;
    i_inst  <= tbl_inst[0];  // held word, valid still low
    repeat (4) begin
      @(negedge clk_100mhz);
      check("reset commit idle", 32'd0, 32'(o_commit_valid));
      check("reset inst ready", 32'd1, 32'(o_inst_ready));
    end
    @(posedge clk_100mhz);
    feed_table();
    wait_commits(n_expected);
    check("chain back-pressure", 32'd1, 32'(saw_stall));
    repeat (20) @(posedge clk_100mhz);  // room for a stray commit
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

// ==== test/ooo_core_asserts.sv ====
`timescale 1ns/1ps

module ooo_core_asserts #(
  parameter int MAX_STALL    = 32,
  parameter bit ALLOW_REPEAT = 1'b0  // no two neighbouring table entries retire alike
) (
  input logic               clk_100mhz,
  input logic               sys_rst,
  input logic               o_inst_ready,
  input logic               o_commit_valid,
  input ooo_pkg::reg_addr_t o_commit_rd,
  input ooo_pkg::xlen_t     o_commit_value
);

  int stall_cnt;  // cycles with ready low

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      stall_cnt <= 0;
    end else if (o_inst_ready) begin
      stall_cnt <= 0;
    end else begin
      stall_cnt <= stall_cnt + 1;
    end
  end

  a_reset_quiet: assert property (@(posedge clk_100mhz) sys_rst |=> !o_commit_valid)
    else $error("commit valid high after a reset edge");

  a_no_repeat: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    (o_commit_valid && $past(o_commit_valid)) |->
      (ALLOW_REPEAT || (o_commit_rd != $past(o_commit_rd))
                    || (o_commit_value != $past(o_commit_value))))
    else $error("same commit repeated on two cycles");

  a_ready_returns: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    stall_cnt < MAX_STALL)
    else $error("instruction ready stuck low");

endmodule

bind ooo_core ooo_core_asserts asserts_inst (
  .clk_100mhz(clk_100mhz), .sys_rst(sys_rst), .o_inst_ready(o_inst_ready),
  .o_commit_valid(o_commit_valid), .o_commit_rd(o_commit_rd),
  .o_commit_value(o_commit_value)
);

// ==== logic/ooo_core.sv ====
`timescale 1ns/1ps

module ooo_core #(
  parameter int RS_DEPTH = 4
) (
  input  logic               clk_100mhz,
  input  logic               sys_rst,
  input  logic               i_inst_valid,
  input  ooo_pkg::inst_t     i_inst,
  output logic               o_inst_ready,
  output logic               o_commit_valid,
  output ooo_pkg::reg_addr_t o_commit_rd,
  output ooo_pkg::xlen_t     o_commit_value
);
  import ooo_pkg::*;

  dispatch_if disp ();

  // issue to register file
  reg_addr_t rf_rs1, rf_rs2, rename_rd;
  xlen_t     rf_rval1, rf_rval2;
  logic      rf_busy1, rf_busy2, rename;
  rob_ix_t   rf_tag1, rf_tag2, rename_tag;

  // issue to rob
  logic      alloc, alloc_ready, look_done1, look_done2;
  reg_addr_t alloc_rd;
  rob_ix_t   alloc_ix, look_ix1, look_ix2;
  xlen_t     look_val1, look_val2;

  // cdb and commit
  logic      cdb_valid;
  rob_ix_t   cdb_rob_ix, commit_ix;
  xlen_t     cdb_value;

  issue_stage issue_inst (
    .i_inst_valid(i_inst_valid), .i_inst(i_inst), .o_inst_ready(o_inst_ready),
    .disp(disp.issue),
    .o_rs1(rf_rs1), .o_rs2(rf_rs2), .i_rval1(rf_rval1), .i_rval2(rf_rval2),
    .i_busy1(rf_busy1), .i_busy2(rf_busy2), .i_tag1(rf_tag1), .i_tag2(rf_tag2),
    .o_rename(rename), .o_rename_rd(rename_rd), .o_rename_tag(rename_tag),
    .i_alloc_ready(alloc_ready), .i_alloc_ix(alloc_ix),
    .o_alloc(alloc), .o_alloc_rd(alloc_rd),
    .o_look_ix1(look_ix1), .o_look_ix2(look_ix2),
    .i_look_done1(look_done1), .i_look_done2(look_done2),
    .i_look_val1(look_val1), .i_look_val2(look_val2)
  );

  register_file regfile_inst (
    .clk_100mhz(clk_100mhz), .sys_rst(sys_rst),
    .i_rs1(rf_rs1), .i_rs2(rf_rs2), .o_rval1(rf_rval1), .o_rval2(rf_rval2),
    .o_busy1(rf_busy1), .o_busy2(rf_busy2), .o_tag1(rf_tag1), .o_tag2(rf_tag2),
    .i_rename(rename), .i_rename_rd(rename_rd), .i_rename_tag(rename_tag),
    .i_commit(o_commit_valid), .i_commit_rd(o_commit_rd),
    .i_commit_value(o_commit_value), .i_commit_ix(commit_ix)
  );

  reorder_buffer rob_inst (
    .clk_100mhz(clk_100mhz), .sys_rst(sys_rst),
    .i_alloc(alloc), .i_alloc_rd(alloc_rd),
    .o_alloc_ready(alloc_ready), .o_alloc_ix(alloc_ix),
    .i_look_ix1(look_ix1), .i_look_ix2(look_ix2),
    .o_look_done1(look_done1), .o_look_done2(look_done2),
    .o_look_val1(look_val1), .o_look_val2(look_val2),
    .i_cdb_valid(cdb_valid), .i_cdb_rob_ix(cdb_rob_ix), .i_cdb_value(cdb_value),
    .o_commit_valid(o_commit_valid), .o_commit_rd(o_commit_rd),
    .o_commit_value(o_commit_value), .o_commit_ix(commit_ix)
  );

  reservation_station #(.RS_DEPTH(RS_DEPTH)) rs_inst (
    .clk_100mhz(clk_100mhz), .sys_rst(sys_rst),
    .disp(disp.station),
    .o_cdb_valid(cdb_valid), .o_cdb_rob_ix(cdb_rob_ix), .o_cdb_value(cdb_value)
  );

endmodule

// ==== logic/reservation_station.sv ====
`timescale 1ns/1ps

module reservation_station #(
  parameter int RS_DEPTH = 4
) (
  input  logic             clk_100mhz,
  input  logic             sys_rst,
  dispatch_if.station      disp,
  output logic             o_cdb_valid,
  output ooo_pkg::rob_ix_t o_cdb_rob_ix,
  output ooo_pkg::xlen_t   o_cdb_value
);
  import ooo_pkg::*;

  localparam int IXW = (RS_DEPTH > 1) ? $clog2(RS_DEPTH) : 1;

  logic [RS_DEPTH-1:0] e_valid;
  logic [RS_DEPTH-1:0] e_i_rdy;
  logic [RS_DEPTH-1:0] e_j_rdy;
  alu_op_t             e_op     [RS_DEPTH];
  rob_ix_t             e_rob_ix [RS_DEPTH];
  xlen_t               e_v_i    [RS_DEPTH];
  xlen_t               e_v_j    [RS_DEPTH];
  rob_ix_t             e_q_i    [RS_DEPTH];
  rob_ix_t             e_q_j    [RS_DEPTH];

  logic [IXW-1:0] free_ix;
  logic [IXW-1:0] sel_ix;
  logic           sel_found;
  logic           wr_en;
  logic           cap_i;
  logic           cap_j;
  xlen_t          alu_res;

  // lowest free slot and lowest ready entry
  always_comb begin
    free_ix   = '0;
    sel_ix    = '0;
    sel_found = 1'b0;
    for (int k = RS_DEPTH - 1; k >= 0; k--) begin
      if (!e_valid[k]) begin
        free_ix = IXW'(k);
      end
      if (e_valid[k] && e_i_rdy[k] && e_j_rdy[k]) begin
        sel_ix    = IXW'(k);
        sel_found = 1'b1;
      end
    end
  end

  assign disp.ready = !(&e_valid);
  assign wr_en      = disp.valid && disp.ready;

  // broadcast landing in the same cycle as the write
  assign cap_i = o_cdb_valid && !disp.i_rdy && (disp.q_i == o_cdb_rob_ix);
  assign cap_j = o_cdb_valid && !disp.j_rdy && (disp.q_j == o_cdb_rob_ix);

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      e_valid <= '0;
    end else begin
      if (sel_found) begin
        e_valid[sel_ix] <= 1'b0;
      end
      if (wr_en) begin
        e_valid[free_ix] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_100mhz) begin
    for (int k = 0; k < RS_DEPTH; k++) begin
      if (o_cdb_valid && !e_i_rdy[k] && (e_q_i[k] == o_cdb_rob_ix)) begin
        e_v_i[k]   <= o_cdb_value;
        e_i_rdy[k] <= 1'b1;
      end
      if (o_cdb_valid && !e_j_rdy[k] && (e_q_j[k] == o_cdb_rob_ix)) begin
        e_v_j[k]   <= o_cdb_value;
        e_j_rdy[k] <= 1'b1;
      end
    end
    if (wr_en) begin
      e_op[free_ix]     <= disp.op;
      e_rob_ix[free_ix] <= disp.rob_ix;
      e_q_i[free_ix]    <= disp.q_i;
      e_q_j[free_ix]    <= disp.q_j;
      e_v_i[free_ix]    <= cap_i ? o_cdb_value : disp.v_i;
      e_v_j[free_ix]    <= cap_j ? o_cdb_value : disp.v_j;
      e_i_rdy[free_ix]  <= disp.i_rdy || cap_i;
      e_j_rdy[free_ix]  <= disp.j_rdy || cap_j;
    end
  end

  always_comb begin
    case (e_op[sel_ix])
      ALU_SUB:  alu_res = e_v_i[sel_ix] - e_v_j[sel_ix];
      ALU_SLL:  alu_res = e_v_i[sel_ix] << e_v_j[sel_ix][4:0];
      ALU_SLT:  alu_res = {31'b0, $signed(e_v_i[sel_ix]) < $signed(e_v_j[sel_ix])};
      ALU_SLTU: alu_res = {31'b0, e_v_i[sel_ix] < e_v_j[sel_ix]};
      ALU_XOR:  alu_res = e_v_i[sel_ix] ^ e_v_j[sel_ix];
      ALU_SRL:  alu_res = e_v_i[sel_ix] >> e_v_j[sel_ix][4:0];
      ALU_SRA:  alu_res = xlen_t'($signed(e_v_i[sel_ix]) >>> e_v_j[sel_ix][4:0]);
      ALU_OR:   alu_res = e_v_i[sel_ix] | e_v_j[sel_ix];
      ALU_AND:  alu_res = e_v_i[sel_ix] & e_v_j[sel_ix];
      default:  alu_res = e_v_i[sel_ix] + e_v_j[sel_ix];
    endcase
  end

  // result register is the cdb, one broadcast per cycle
  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      o_cdb_valid <= 1'b0;
    end else begin
      o_cdb_valid <= sel_found;
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (sel_found) begin
      o_cdb_rob_ix <= e_rob_ix[sel_ix];
      o_cdb_value  <= alu_res;
    end
  end

endmodule

// ==== logic/reorder_buffer.sv ====
`timescale 1ns/1ps

module reorder_buffer (
  input  logic               clk_100mhz,
  input  logic               sys_rst,
  // allocation from issue
  input  logic               i_alloc,
  input  ooo_pkg::reg_addr_t i_alloc_rd,
  output logic               o_alloc_ready,
  output ooo_pkg::rob_ix_t   o_alloc_ix,
  // operand lookups
  input  ooo_pkg::rob_ix_t   i_look_ix1,
  input  ooo_pkg::rob_ix_t   i_look_ix2,
  output logic               o_look_done1,
  output logic               o_look_done2,
  output ooo_pkg::xlen_t     o_look_val1,
  output ooo_pkg::xlen_t     o_look_val2,
  // common data bus
  input  logic               i_cdb_valid,
  input  ooo_pkg::rob_ix_t   i_cdb_rob_ix,
  input  ooo_pkg::xlen_t     i_cdb_value,
  // commit
  output logic               o_commit_valid,
  output ooo_pkg::reg_addr_t o_commit_rd,
  output ooo_pkg::xlen_t     o_commit_value,
  output ooo_pkg::rob_ix_t   o_commit_ix
);
  import ooo_pkg::*;

  localparam int CNT_W = $clog2(ROB_DEPTH) + 1;
  typedef logic [CNT_W-1:0] cnt_t;

  reg_addr_t              ent_rd  [ROB_DEPTH];
  xlen_t                  ent_val [ROB_DEPTH];
  logic [ROB_DEPTH-1:0]   ent_done;
  rob_ix_t                head;
  rob_ix_t                tail;
  cnt_t                   count;
  logic                   commit_go;

  assign o_alloc_ready = (count != cnt_t'(ROB_DEPTH));
  assign o_alloc_ix    = tail;

  // answered straight from the entries, a result on the cdb this cycle is not seen
  assign o_look_done1 = ent_done[i_look_ix1];
  assign o_look_done2 = ent_done[i_look_ix2];
  assign o_look_val1  = ent_val[i_look_ix1];
  assign o_look_val2  = ent_val[i_look_ix2];

  assign commit_go = (count != '0) && ent_done[head];

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      head           <= '0;
      tail           <= '0;
      count          <= '0;
      ent_done       <= '0;
      o_commit_valid <= 1'b0;
    end else begin
      o_commit_valid <= commit_go;
      if (i_cdb_valid) begin
        ent_done[i_cdb_rob_ix] <= 1'b1;
      end
      if (i_alloc) begin
        ent_done[tail] <= 1'b0;  // fresh entry waits for its result
        tail           <= tail + 1'b1;
      end
      if (commit_go) begin
        head <= head + 1'b1;
      end
      count <= count + cnt_t'(i_alloc) - cnt_t'(commit_go);
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (i_alloc) begin
      ent_rd[tail] <= i_alloc_rd;
    end
    if (i_cdb_valid) begin
      ent_val[i_cdb_rob_ix] <= i_cdb_value;
    end
    if (commit_go) begin
      o_commit_rd    <= ent_rd[head];
      o_commit_value <= ent_val[head];
      o_commit_ix    <= head;  // lets the register file match its tag
    end
  end

endmodule

// ==== issue/register_file.sv ====
`timescale 1ns/1ps

module register_file (
  input  logic               clk_100mhz,
  input  logic               sys_rst,
  // issue reads
  input  ooo_pkg::reg_addr_t i_rs1,
  input  ooo_pkg::reg_addr_t i_rs2,
  output ooo_pkg::xlen_t     o_rval1,
  output ooo_pkg::xlen_t     o_rval2,
  output logic               o_busy1,
  output logic               o_busy2,
  output ooo_pkg::rob_ix_t   o_tag1,
  output ooo_pkg::rob_ix_t   o_tag2,
  // rename from issue
  input  logic               i_rename,
  input  ooo_pkg::reg_addr_t i_rename_rd,
  input  ooo_pkg::rob_ix_t   i_rename_tag,
  // in-order commit
  input  logic               i_commit,
  input  ooo_pkg::reg_addr_t i_commit_rd,
  input  ooo_pkg::xlen_t     i_commit_value,
  input  ooo_pkg::rob_ix_t   i_commit_ix
);
  import ooo_pkg::*;

  xlen_t       regs [32];  // entry 0 never written
  rob_ix_t     tags [32];
  logic [31:0] busy;

  // x0 always reads zero and idle
  assign o_rval1 = (i_rs1 == '0) ? '0 : regs[i_rs1];
  assign o_rval2 = (i_rs2 == '0) ? '0 : regs[i_rs2];
  assign o_busy1 = (i_rs1 != '0) && busy[i_rs1];
  assign o_busy2 = (i_rs2 != '0) && busy[i_rs2];
  assign o_tag1  = tags[i_rs1];
  assign o_tag2  = tags[i_rs2];

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      busy <= '0;
      for (int r = 0; r < 32; r++) begin
        regs[r] <= '0;
      end
    end else begin
      if (i_commit && (i_commit_rd != '0)) begin
        regs[i_commit_rd] <= i_commit_value;
        if (tags[i_commit_rd] == i_commit_ix) begin
          busy[i_commit_rd] <= 1'b0;  // only the newest producer frees it
        end
      end
      // later assignment, so a same-cycle rename keeps the register busy
      if (i_rename) begin
        busy[i_rename_rd] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (i_rename) begin
      tags[i_rename_rd] <= i_rename_tag;
    end
  end

endmodule

// ==== issue/issue_stage.sv ====
`timescale 1ns/1ps

module issue_stage (
  input  logic               i_inst_valid,
  input  ooo_pkg::inst_t     i_inst,
  output logic               o_inst_ready,
  dispatch_if.issue          disp,
  // register file side
  output ooo_pkg::reg_addr_t o_rs1,
  output ooo_pkg::reg_addr_t o_rs2,
  input  ooo_pkg::xlen_t     i_rval1,
  input  ooo_pkg::xlen_t     i_rval2,
  input  logic               i_busy1,
  input  logic               i_busy2,
  input  ooo_pkg::rob_ix_t   i_tag1,
  input  ooo_pkg::rob_ix_t   i_tag2,
  output logic               o_rename,
  output ooo_pkg::reg_addr_t o_rename_rd,
  output ooo_pkg::rob_ix_t   o_rename_tag,
  // reorder buffer side
  input  logic               i_alloc_ready,
  input  ooo_pkg::rob_ix_t   i_alloc_ix,
  output logic               o_alloc,
  output ooo_pkg::reg_addr_t o_alloc_rd,
  output ooo_pkg::rob_ix_t   o_look_ix1,
  output ooo_pkg::rob_ix_t   o_look_ix2,
  input  logic               i_look_done1,
  input  logic               i_look_done2,
  input  ooo_pkg::xlen_t     i_look_val1,
  input  ooo_pkg::xlen_t     i_look_val2
);
  import ooo_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       alt_bit;   // inst[30], selects sub and sra
  reg_addr_t  rd;
  xlen_t      imm;
  logic       is_reg;
  logic       is_imm;
  logic       is_alu;
  logic       fire;
  alu_op_t    alu_op;

  assign opcode  = i_inst[6:0];
  assign rd      = i_inst[11:7];
  assign funct3  = i_inst[14:12];
  assign alt_bit = i_inst[30];
  assign imm     = {{20{i_inst[31]}}, i_inst[31:20]};  // i-type, shamt sits in [4:0]

  assign is_reg = (opcode == OPC_OP);
  assign is_imm = (opcode == OPC_OPIMM);
  assign is_alu = is_reg || is_imm;

  // anything else is taken at once and dropped
  assign o_inst_ready = !is_alu || (i_alloc_ready && disp.ready);
  assign fire         = i_inst_valid && is_alu && i_alloc_ready && disp.ready;

  always_comb begin
    alu_op = ALU_ADD;
    case (funct3)
      3'b000:  alu_op = (is_reg && alt_bit) ? ALU_SUB : ALU_ADD;  // no subi
      3'b001:  alu_op = ALU_SLL;
      3'b010:  alu_op = ALU_SLT;
      3'b011:  alu_op = ALU_SLTU;
      3'b100:  alu_op = ALU_XOR;
      3'b101:  alu_op = alt_bit ? ALU_SRA : ALU_SRL;
      3'b110:  alu_op = ALU_OR;
      default: alu_op = ALU_AND;
    endcase
  end

  assign o_rs1      = i_inst[19:15];
  assign o_rs2      = i_inst[24:20];
  assign o_look_ix1 = i_tag1;
  assign o_look_ix2 = i_tag2;

  // operand i: register, finished rob entry, or wait on the tag
  always_comb begin
    disp.v_i   = i_rval1;
    disp.q_i   = i_tag1;
    disp.i_rdy = 1'b1;
    if (i_busy1) begin
      disp.i_rdy = i_look_done1;
      disp.v_i   = i_look_val1;
    end
  end

  // operand j, the immediate takes its place for op-imm
  always_comb begin
    disp.v_j   = i_rval2;
    disp.q_j   = i_tag2;
    disp.j_rdy = 1'b1;
    if (is_imm) begin
      disp.v_j = imm;
    end else if (i_busy2) begin
      disp.j_rdy = i_look_done2;
      disp.v_j   = i_look_val2;
    end
  end

  assign disp.valid  = fire;
  assign disp.op     = alu_op;
  assign disp.rob_ix = i_alloc_ix;

  assign o_alloc      = fire;
  assign o_alloc_rd   = rd;
  assign o_rename     = fire && (rd != '0);  // x0 keeps no mapping
  assign o_rename_rd  = rd;
  assign o_rename_tag = i_alloc_ix;

endmodule

// ==== common/dispatch_if.sv ====
`timescale 1ns/1ps

interface dispatch_if;
  import ooo_pkg::*;

  logic    valid;
  logic    ready;   // station has a free entry
  alu_op_t op;
  rob_ix_t rob_ix;  // destination tag of the instruction
  xlen_t   v_i;
  xlen_t   v_j;
  rob_ix_t q_i;     // producer tags, meaningful while not ready
  rob_ix_t q_j;
  logic    i_rdy;
  logic    j_rdy;

  modport issue (
    output valid, op, rob_ix, v_i, v_j, q_i, q_j, i_rdy, j_rdy,
    input  ready
  );

  modport station (
    input  valid, op, rob_ix, v_i, v_j, q_i, q_j, i_rdy, j_rdy,
    output ready
  );

endinterface

// ==== common/ooo_pkg.sv ====
package ooo_pkg;

  // data and instruction words
  typedef logic [31:0] xlen_t;
  typedef logic [31:0] inst_t;

  // architectural register number, x0 to x31
  typedef logic [4:0] reg_addr_t;

  // reorder buffer sizing, the index type is shared by every stage
  localparam int ROB_DEPTH = 8;
  typedef logic [$clog2(ROB_DEPTH)-1:0] rob_ix_t;

  // alu operation code carried from issue to the station
  typedef logic [3:0] alu_op_t;

  localparam alu_op_t ALU_ADD  = 4'd0;
  localparam alu_op_t ALU_SUB  = 4'd1;
  localparam alu_op_t ALU_SLL  = 4'd2;
  localparam alu_op_t ALU_SLT  = 4'd3;   // signed compare
  localparam alu_op_t ALU_SLTU = 4'd4;   // unsigned compare
  localparam alu_op_t ALU_XOR  = 4'd5;
  localparam alu_op_t ALU_SRL  = 4'd6;
  localparam alu_op_t ALU_SRA  = 4'd7;   // sign fill
  localparam alu_op_t ALU_OR   = 4'd8;
  localparam alu_op_t ALU_AND  = 4'd9;

  // the two supported major opcodes
  localparam logic [6:0] OPC_OP    = 7'b0110011;  // register-register
  localparam logic [6:0] OPC_OPIMM = 7'b0010011;  // register-immediate

endpackage
